//--- list.f
+incdir+src
src/fas_pkg.sv
src/fir_filter.sv
src/slot_counter.sv
src/frame_sequencer.sv
src/frame_buffer.sv
src/peak_picker.sv
src/fas_top.sv
tb/tb_fas.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

TOP=tb_fas
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

echo "Building $TOP"
if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -Mdir "$OBJ_DIR" -f list.f; then
  echo "Build failed"
  exit 1
fi

echo "Running $TOP"
if ! "./$OBJ_DIR/V$TOP" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
fi

echo "Result: fail"
exit 1

//--- src/fas_config.svh
////////////////////////////////////////////////////////////
// Build-time sizes for the filter and analysis front end
// FAS_FRAME must be a power of two, at most 16 (bin_t width)
////////////////////////////////////////////////////////////
`ifndef FAS_CONFIG_SVH
`define FAS_CONFIG_SVH

// Number of FIR taps, coefficient table in fas_pkg must match
`define FAS_TAPS 32

// Filtered samples per analysis frame
`define FAS_FRAME 16

// Input and filtered sample width, two's complement
`define FAS_SAMPLE_W 16

// Coefficient width, two's complement fixed point
`define FAS_COEF_W 20

// Fractional bits of the coefficients (Q16)
`define FAS_FRAC 16

`endif

//--- src/fas_pkg.sv
////////////////////////////////////////////////////////////
// Shared types and the low-pass coefficient set
// Table length must equal FAS_TAPS
////////////////////////////////////////////////////////////
`include "fas_config.svh"

package fas_pkg;

  localparam int ACC_W = `FAS_SAMPLE_W + `FAS_COEF_W + $clog2(`FAS_TAPS);

  typedef logic signed [`FAS_SAMPLE_W-1:0]   sample_t;  // Raw and filtered samples
  typedef logic signed [`FAS_COEF_W-1:0]     coef_t;    // Q16 coefficient
  typedef logic signed [ACC_W-1:0]           acc_t;     // Room for all tap products
  typedef logic [2*`FAS_SAMPLE_W-1:0]        power_t;   // Sample squared
  typedef logic [$clog2(`FAS_FRAME)-1:0]     bin_t;     // Index within a frame
  typedef sample_t [`FAS_FRAME-1:0]          frame_t;   // One whole frame

  // Symmetric 32-tap low-pass response, Q16
  localparam coef_t FIR_COEF [`FAS_TAPS] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E
  };

endpackage

//--- src/fas_top.sv
////////////////////////////////////////////////////////////
// No back-pressure, every input strobe is taken
// done comes 6 cycles after the 16th fir_valid of a frame
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fas_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d,
  output logic             done,
  output fas_pkg::bin_t    freq,
  output fas_pkg::power_t  peak_power
);

  logic            wr_en;
  fas_pkg::bin_t   wr_slot;
  logic            frame_ready;
  fas_pkg::frame_t frame;

  fir_filter i_fir_filter (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_sequencer i_frame_sequencer (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .wr_en       (wr_en),
    .wr_slot     (wr_slot),
    .frame_ready (frame_ready)
  );

  frame_buffer i_frame_buffer (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_slot (wr_slot),
    .wr_data (fir_d),
    .frame   (frame)
  );

  peak_picker i_peak_picker (
    .clk         (clk),
    .rst         (rst),
    .frame_ready (frame_ready),
    .frame       (frame),
    .done        (done),
    .freq        (freq),
    .peak_power  (peak_power)
  );

endmodule

//--- src/fir_filter.sv
////////////////////////////////////////////////////////////
// Output includes the sample accepted on the same strobe
// Any idle edge restarts the 32-sample fill before fir_valid
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_config.svh"

module fir_filter (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d
);

  localparam int TAPS   = `FAS_TAPS;
  localparam int SW     = `FAS_SAMPLE_W;
  localparam int FRAC   = `FAS_FRAC;
  localparam int ACC_W  = fas_pkg::ACC_W;
  localparam int FILL_W = $clog2(TAPS + 1);

  // The incoming sample is tap 0, so only TAPS-1 older samples are stored
  fas_pkg::sample_t taps [TAPS-1];
  logic [FILL_W-1:0] fill_cnt;  // Consecutive accepted samples, saturates
  fas_pkg::acc_t     sum;
  fas_pkg::sample_t  fir_next;

  ////////////////////////////////////////////////////////////
  // Multiply-accumulate over the window
  ////////////////////////////////////////////////////////////
  always_comb begin
    sum = fas_pkg::acc_t'(data) * fas_pkg::acc_t'(fas_pkg::FIR_COEF[0]);
    for (int k = 1; k < TAPS; k++) begin
      sum = sum + fas_pkg::acc_t'(taps[k-1]) * fas_pkg::acc_t'(fas_pkg::FIR_COEF[k]);
    end
  end

  // Keep sign and the 15 bits above the binary point, bump negatives by one
  assign fir_next = {sum[ACC_W-1], sum[FRAC+SW-2:FRAC]}
                  + {{(SW-1){1'b0}}, sum[ACC_W-1]};

  ////////////////////////////////////////////////////////////
  // Delay line, fill tracking and output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < TAPS-1; k++) begin
        taps[k] <= '0;
      end
      fill_cnt  <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else if (data_valid) begin
      taps[0] <= data;  // Newest sample enters here
      for (int k = 1; k < TAPS-1; k++) begin
        taps[k] <= taps[k-1];
      end
      if (fill_cnt != FILL_W'(TAPS)) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      fir_valid <= (fill_cnt >= FILL_W'(TAPS - 1));  // This sample completes the window
      fir_d     <= fir_next;
    end else begin
      fill_cnt  <= '0;  // Taps are kept, only the count restarts
      fir_valid <= 1'b0;
    end
  end

  // A strobe is only issued once a full window of consecutive samples exists
  a_valid_needs_fill: assert property (
    @(posedge clk) disable iff (rst)
    $rose(fir_valid) |-> fill_cnt == FILL_W'(TAPS)
  );

endmodule

//--- src/frame_buffer.sv
////////////////////////////////////////////////////////////
// One write per cycle, all slots readable in parallel
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_config.svh"

module frame_buffer (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  fas_pkg::bin_t    wr_slot,
  input  fas_pkg::sample_t wr_data,
  output fas_pkg::frame_t  frame
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame <= '0;
    end else if (wr_en) begin
      frame[wr_slot] <= wr_data;  // Other slots keep their sample
    end
  end

endmodule

//--- src/frame_sequencer.sv
////////////////////////////////////////////////////////////
// A cycle without fir_valid in COLLECT drops the partial frame
// frame_ready follows the last slot write by one cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_config.svh"

module frame_sequencer (
  input  logic          clk,
  input  logic          rst,
  input  logic          fir_valid,
  output logic          wr_en,
  output fas_pkg::bin_t wr_slot,
  output logic          frame_ready
);

  typedef enum logic {
    IDLE,
    COLLECT
  } state_t;

  state_t        state;
  logic          clear;
  logic          advance;
  fas_pkg::bin_t slot;
  logic          last;

  slot_counter #(
    .LENGTH (`FAS_FRAME)
  ) i_slot_counter (
    .clk     (clk),
    .rst     (rst),
    .clear   (clear),
    .advance (advance),
    .slot    (slot),
    .last    (last)
  );

  assign clear   = (state == COLLECT) && !fir_valid;  // Gap abandons the frame
  assign advance = fir_valid;
  assign wr_en   = fir_valid;
  assign wr_slot = slot;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= IDLE;
      frame_ready <= 1'b0;
    end else begin
      case (state)
        IDLE:    if (fir_valid) state <= COLLECT;
        COLLECT: if (!fir_valid) state <= IDLE;
        default: state <= IDLE;
      endcase
      frame_ready <= fir_valid && last;  // Slot 15 written on this edge
    end
  end

  a_ready_single: assert property (
    @(posedge clk) disable iff (rst)
    frame_ready |=> !frame_ready
  );

endmodule

//--- src/peak_picker.sv
////////////////////////////////////////////////////////////
// Squaring stage then log2(FAS_FRAME) compare levels
// Ties go to the higher index, new frame accepted every cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_config.svh"

module peak_picker (
  input  logic            clk,
  input  logic            rst,
  input  logic            frame_ready,
  input  fas_pkg::frame_t frame,
  output logic            done,
  output fas_pkg::bin_t   freq,
  output fas_pkg::power_t peak_power
);

  localparam int N      = `FAS_FRAME;
  localparam int LEVELS = $clog2(N);
  localparam int NODES  = 2 * N - 1;

  // All levels of the tree share one node array, leaves first
  fas_pkg::power_t pw [NODES];
  fas_pkg::bin_t   ix [NODES];
  logic [LEVELS:0] vld;  // Bit l marks level l holding a live frame

  // First node of a tree level
  function automatic int base(input int lvl);
    return 2 * N - ((2 * N) >> lvl);
  endfunction

  function automatic fas_pkg::power_t square(input fas_pkg::sample_t s);
    logic signed [2*`FAS_SAMPLE_W-1:0] w;
    w = s;
    return fas_pkg::power_t'(w * w);
  endfunction

  ////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int n = 0; n < NODES; n++) begin
        pw[n] <= '0;
        ix[n] <= '0;
      end
      vld <= '0;
    end else begin
      vld <= {vld[LEVELS-1:0], frame_ready};

      if (frame_ready) begin
        for (int i = 0; i < N; i++) begin
          pw[i] <= square(frame[i]);
          ix[i] <= fas_pkg::bin_t'(i);
        end
      end

      // Each level halves the candidates of the level before it
      for (int l = 1; l <= LEVELS; l++) begin
        if (vld[l-1]) begin
          for (int i = 0; i < (N >> l); i++) begin
            if (pw[base(l-1) + 2*i] > pw[base(l-1) + 2*i + 1]) begin
              pw[base(l) + i] <= pw[base(l-1) + 2*i];
              ix[base(l) + i] <= ix[base(l-1) + 2*i];
            end else begin
              pw[base(l) + i] <= pw[base(l-1) + 2*i + 1];  // Equal goes high
              ix[base(l) + i] <= ix[base(l-1) + 2*i + 1];
            end
          end
        end
      end
    end
  end

  // Root node only loads with a live frame, so results hold between done pulses
  assign done       = vld[LEVELS];
  assign freq       = ix[NODES-1];
  assign peak_power = pw[NODES-1];

  a_done_latency: assert property (
    @(posedge clk) disable iff (rst)
    done |-> $past(frame_ready, LEVELS + 1)
  );

endmodule

//--- src/slot_counter.sv
////////////////////////////////////////////////////////////
// LENGTH must fit the bin_t range of the package
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_config.svh"

module slot_counter #(
  parameter int LENGTH = `FAS_FRAME
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          clear,
  input  logic          advance,
  output fas_pkg::bin_t slot,
  output logic          last
);

  assign last = (slot == fas_pkg::bin_t'(LENGTH - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot <= '0;
    end else if (clear) begin
      slot <= '0;  // Clear wins over advance
    end else if (advance) begin
      slot <= last ? '0 : slot + 1'b1;
    end
  end

  a_slot_in_range: assert property (
    @(posedge clk) disable iff (rst)
    int'(slot) < LENGTH
  );

endmodule

//--- tb/tb_fas.sv
////////////////////////////////////////////////////////////
// Directed tests for fas_top against a software model
// Every cycle after reset is driven through drive_cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fas_config.svh"

module tb_fas;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 4;
  localparam int RANDOM_LEN   = 300;  // Random stream samples
  localparam int PEAK_LEN     = 64;   // Samples fed by the frame peak test
  localparam int DRAIN        = 7;    // Idle cycles that let done arrive
  localparam int TEST_CYCLES  = RESET_CYCLES + 72 + RANDOM_LEN + 41
                              + PEAK_LEN + DRAIN + 88 + DRAIN;
  localparam int LIMIT_CYCLES = 2 * TEST_CYCLES + 100;

  logic              clk;
  logic              rst;
  logic              data_valid;
  fas_pkg::sample_t  data;
  logic              fir_valid;
  fas_pkg::sample_t  fir_d;
  logic              done;
  fas_pkg::bin_t     freq;
  fas_pkg::power_t   peak_power;

  // Model state
  fas_pkg::sample_t  win [`FAS_TAPS];   // Newest accepted sample at index 0
  int                fill;
  fas_pkg::sample_t  exp_d;
  fas_pkg::sample_t  frm_q [$];         // Outputs of the frame being collected
  int                due_q [$];         // Cycle at which each done is expected
  fas_pkg::bin_t     freq_q [$];
  fas_pkg::power_t   power_q [$];
  fas_pkg::bin_t     held_freq;
  fas_pkg::power_t   held_power;
  int                n_frames;          // Frames completed by the model

  int cyc;
  int n_done;
  int n_checks;
  int n_value_err;
  int n_other_err;

  fas_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .done       (done),
    .freq       (freq),
    .peak_power (peak_power)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    n_checks++;
    assert (actual === expected) else begin
      n_value_err++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    n_checks++;
    assert (cond) else begin
      n_other_err++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  // Sum over the window, then sign plus bits 30..16, negatives bumped by one
  function automatic fas_pkg::sample_t filter_model();
    longint                   acc;
    logic                     neg;
    logic [`FAS_SAMPLE_W-1:0] r;
    acc = 0;
    for (int k = 0; k < `FAS_TAPS; k++) begin
      acc += longint'(win[k]) * longint'(fas_pkg::FIR_COEF[k]);
    end
    neg = (acc < 0);
    r   = {neg, acc[`FAS_FRAC+`FAS_SAMPLE_W-2:`FAS_FRAC]};
    return fas_pkg::sample_t'(r + 16'(neg));
  endfunction

  // Collect strobed outputs and drop the partial frame on a gap
  task automatic track_frame(input logic valid);
    longint best_p;
    longint p;
    int     best_i;
    if (!valid) begin
      frm_q.delete();
    end else begin
      frm_q.push_back(exp_d);
      if (frm_q.size() == `FAS_FRAME) begin
        best_p = -1;
        best_i = 0;
        for (int i = 0; i < `FAS_FRAME; i++) begin
          p = longint'(frm_q[i]) * longint'(frm_q[i]);
          if (p >= best_p) begin  // Equal energy moves to the higher index
            best_p = p;
            best_i = i;
          end
        end
        due_q.push_back(cyc + 6);
        freq_q.push_back(fas_pkg::bin_t'(best_i));
        power_q.push_back(fas_pkg::power_t'(best_p));
        frm_q.delete();
        n_frames++;
      end
    end
  endtask

  task automatic check_done();
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      expect_true(done, "done missing six cycles after a completed frame");
      held_freq  = freq_q.pop_front();
      held_power = power_q.pop_front();
      void'(due_q.pop_front());
    end else begin
      expect_true(!done, "done pulsed with no completed frame due");
    end
    if (done) n_done++;
    compare_value("freq", 32'(held_freq), 32'(freq));
    compare_value("peak_power", held_power, peak_power);
  endtask

  // One clock cycle that starts and ends 1 ns after a rising edge
  task automatic drive_cycle(input logic valid, input fas_pkg::sample_t value);
    logic exp_valid;
    data_valid = valid;
    data       = value;
    if (valid) begin
      for (int k = `FAS_TAPS - 1; k > 0; k--) begin
        win[k] = win[k-1];
      end
      win[0] = value;
      exp_d  = filter_model();
      if (fill < `FAS_TAPS) fill++;
      exp_valid = (fill == `FAS_TAPS);
    end else begin
      fill      = 0;  // Window contents stay
      exp_valid = 1'b0;
    end
    @(posedge clk);
    #1;
    cyc++;
    compare_value("fir_valid", 32'(exp_valid), 32'(fir_valid));
    compare_value("fir_d", 32'(exp_d), 32'(fir_d));
    track_frame(exp_valid);
    check_done();
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic reset_state();
    compare_value("fir_valid", 32'd0, 32'(fir_valid));
    compare_value("done", 32'd0, 32'(done));
    compare_value("fir_d", 32'd0, 32'(fir_d));
    compare_value("freq", 32'd0, 32'(freq));
    compare_value("peak_power", 32'd0, peak_power);
  endtask

  task automatic impulse_response();
    for (int n = 0; n < 31; n++) drive_cycle(1'b1, '0);
    drive_cycle(1'b1, 16'sh4000);
    for (int n = 0; n < 40; n++) drive_cycle(1'b1, '0);
  endtask

  task automatic random_stream();
    for (int n = 0; n < RANDOM_LEN; n++) begin
      drive_cycle(1'b1, fas_pkg::sample_t'($urandom));
    end
  endtask

  task automatic valid_gating();
    int first;
    first = -1;
    drive_cycle(1'b0, '0);  // One-cycle gap
    expect_true(!fir_valid, "fir_valid stayed high after a gap in data_valid");
    for (int n = 1; n <= 40; n++) begin
      drive_cycle(1'b1, fas_pkg::sample_t'($urandom));
      if (fir_valid && first < 0) first = n;
    end
    expect_true(first == `FAS_TAPS,
                "fir_valid did not first rise on the 32nd sample after the gap");
  endtask

  task automatic frame_peak();
    int start;
    start = n_done;
    for (int n = 0; n < PEAK_LEN; n++) begin
      drive_cycle(1'b1, fas_pkg::sample_t'($urandom));
    end
    for (int n = 0; n < DRAIN; n++) drive_cycle(1'b0, '0);
    expect_true(n_done - start >= 3, "fewer than three frames reported during a long stream");
  endtask

  task automatic abandoned_frame();
    int start;
    start = n_done;
    for (int n = 0; n < 40; n++) begin  // Nine strobes leave the frame partial
      drive_cycle(1'b1, fas_pkg::sample_t'($urandom));
    end
    drive_cycle(1'b0, '0);
    for (int n = 0; n < 47; n++) begin  // Refill and then exactly sixteen strobes
      drive_cycle(1'b1, fas_pkg::sample_t'($urandom));
    end
    for (int n = 0; n < DRAIN; n++) drive_cycle(1'b0, '0);
    expect_true(n_done - start == 1, "partial frame was reported or full frame was lost");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    data_valid  = 1'b0;
    data        = '0;
    fill        = 0;
    exp_d       = '0;
    held_freq   = '0;
    held_power  = '0;
    n_frames    = 0;
    cyc         = 0;
    n_done      = 0;
    n_checks    = 0;
    n_value_err = 0;
    n_other_err = 0;
    for (int k = 0; k < `FAS_TAPS; k++) win[k] = '0;
    void'($urandom(32'h0a78e645));
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    reset_state();
    impulse_response();
    random_stream();
    valid_gating();
    frame_peak();
    abandoned_frame();
    expect_true(n_done == n_frames,
                "number of done pulses differs from the number of completed frames");

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             n_checks, n_value_err, n_other_err);
    if (n_value_err + n_other_err == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not finish", LIMIT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
